/* rtl/dcache_pkg.sv */
package dcache_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int XLEN   = 32;        // data word
  localparam int ADDR_W = 32;        // byte address
  localparam int BE_W   = XLEN / 8;  // bytes per word

  // --------------------
  // shared types
  // --------------------
  typedef logic [XLEN-1:0]   word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [BE_W-1:0]   be_t;

  // cpu access size
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } mem_size_e;

endpackage

/* rtl/cache_ram.sv */
`timescale 1ns/1ps

module cache_ram #(
  parameter int  DEPTH     = 16,
  parameter type payload_t = logic [31:0]
) (
  input  logic                     clk_i,
  input  logic [$clog2(DEPTH)-1:0] addr_i,
  input  logic                     we_i,
  input  payload_t                 wdata_i,
  output payload_t                 rdata_o
);

  payload_t mem_q [DEPTH];  // storage array

  // read returns the old entry on a write
  always_ff @(posedge clk_i)
  begin
    if (we_i)
    begin
      mem_q[addr_i] <= wdata_i;
    end
    rdata_o <= mem_q[addr_i];  // one cycle read latency
  end

endmodule

/* rtl/way_array.sv */
`timescale 1ns/1ps

module way_array import dcache_pkg::*; #(
  parameter  int SETS       = 16,
  parameter  int LINE_WORDS = 4,
  localparam int IDX_W      = $clog2(SETS),
  localparam int TAG_W      = ADDR_W - IDX_W - $clog2(LINE_WORDS * BE_W)
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [IDX_W-1:0]       idx_i,
  input  logic                   tag_we_i,   // tag, valid and dirty
  input  logic                   data_we_i,
  input  logic [TAG_W-1:0]       tag_i,
  input  logic                   dirty_i,
  input  word_t [LINE_WORDS-1:0] line_i,
  input  logic [TAG_W-1:0]       cmp_tag_i,
  output logic                   hit_o,
  output logic                   valid_o,
  output logic                   dirty_o,
  output logic [TAG_W-1:0]       tag_o,
  output word_t [LINE_WORDS-1:0] line_o
);

  logic [SETS-1:0]  valid_q;
  logic [SETS-1:0]  dirty_q;
  logic [IDX_W-1:0] idx_q;  // aligned with ram output
  logic [TAG_W-1:0] cmp_q;

  cache_ram #(
    .DEPTH     (SETS),
    .payload_t (logic [TAG_W-1:0])
  ) u_tag_ram (
    .clk_i   (clk_i),
    .addr_i  (idx_i),
    .we_i    (tag_we_i),
    .wdata_i (tag_i),
    .rdata_o (tag_o)
  );

  cache_ram #(
    .DEPTH     (SETS),
    .payload_t (word_t [LINE_WORDS-1:0])
  ) u_data_ram (
    .clk_i   (clk_i),
    .addr_i  (idx_i),
    .we_i    (data_we_i),
    .wdata_i (line_i),
    .rdata_o (line_o)
  );

  // valid and dirty per set in flops
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      valid_q <= '0;
      dirty_q <= '0;
    end
    else if (tag_we_i)
    begin
      valid_q[idx_i] <= 1'b1;  // every tag write installs or keeps a line
      dirty_q[idx_i] <= dirty_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    idx_q <= idx_i;
    cmp_q <= cmp_tag_i;
  end

  assign valid_o = valid_q[idx_q];
  assign dirty_o = dirty_q[idx_q];
  assign hit_o   = valid_o && (tag_o == cmp_q);

endmodule

/* rtl/burst_engine.sv */
`timescale 1ns/1ps

module burst_engine import dcache_pkg::*; #(
  parameter int LINE_WORDS = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   start_i,
  input  logic                   we_i,       // 1 for write burst
  input  addr_t                  adr_i,      // line aligned
  input  word_t [LINE_WORDS-1:0] line_i,     // eviction line
  output logic                   done_o,
  output word_t [LINE_WORDS-1:0] line_o,     // assembled fill line
  output logic                   bus_req_o,
  output logic                   bus_we_o,
  output addr_t                  bus_adr_o,
  input  logic                   bus_gnt_i,
  input  word_t                  bus_rdata_i,
  input  logic                   bus_rvalid_i,
  output word_t                  bus_wdata_o,
  input  logic                   bus_wready_i
);

  localparam int CNT_W = (LINE_WORDS > 1) ? $clog2(LINE_WORDS) : 1;

  typedef enum logic [1:0] {E_IDLE, E_ADDR, E_BURST} estate_e;

  estate_e                state_q;
  logic                   we_q;
  addr_t                  adr_q;
  logic [CNT_W-1:0]       cnt_q;   // beat counter
  word_t [LINE_WORDS-1:0] buf_q;   // shift out or assemble in
  logic                   beat;

  assign beat = (state_q == E_BURST) && (we_q ? bus_wready_i : bus_rvalid_i);

  // bus side
  assign bus_req_o   = (state_q == E_ADDR);  // address phase
  assign bus_we_o    = we_q;
  assign bus_adr_o   = adr_q;
  assign bus_wdata_o = buf_q[0];             // current word of write burst
  assign line_o      = buf_q;

  // --------------------
  // control
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= E_IDLE;
      we_q    <= 1'b0;
      cnt_q   <= '0;
      done_o  <= 1'b0;
    end
    else
    begin
      done_o <= 1'b0;  // single cycle pulse
      case (state_q)
        E_IDLE:
          if (start_i)
          begin
            state_q <= E_ADDR;
            we_q    <= we_i;
          end
        E_ADDR:
          if (bus_gnt_i)
          begin
            state_q <= E_BURST;
            cnt_q   <= '0;
          end
        E_BURST:
          if (beat)
          begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == CNT_W'(LINE_WORDS - 1))
            begin
              state_q <= E_IDLE;  // last beat
              done_o  <= 1'b1;
            end
          end
        default: state_q <= E_IDLE;
      endcase
    end
  end

  // --------------------
  // payload
  // --------------------
  always_ff @(posedge clk_i)
  begin
    if (start_i && state_q == E_IDLE)
    begin
      adr_q <= adr_i;
      buf_q <= line_i;
    end
    else if (beat)
    begin
      if (we_q)
        buf_q <= buf_q >> XLEN;         // next word to bit 0
      else
        buf_q[cnt_q] <= bus_rdata_i;    // ascending word order
    end
  end

  // request held until memory grants it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    bus_req_o && !bus_gnt_i |=> bus_req_o && $stable(bus_adr_o));

endmodule

/* rtl/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; #(
  parameter  int WAYS       = 2,
  parameter  int SETS       = 16,
  parameter  int LINE_WORDS = 4,
  localparam int IDX_W      = $clog2(SETS),
  localparam int TAG_W      = ADDR_W - IDX_W - $clog2(LINE_WORDS * BE_W)
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_i,
  input  logic                              we_i,
  input  addr_t                             addr_i,
  input  mem_size_e                         size_i,
  input  word_t                             wdata_i,
  output word_t                             rdata_o,
  output logic                              ack_o,
  input  logic                              flush_i,
  output logic                              flush_done_o,
  output logic [IDX_W-1:0]                  way_idx_o,
  output logic [WAYS-1:0]                   way_tag_we_o,
  output logic [WAYS-1:0]                   way_data_we_o,
  output logic [TAG_W-1:0]                  way_tag_o,
  output logic                              way_dirty_o,
  output word_t [LINE_WORDS-1:0]            way_line_o,
  input  logic [WAYS-1:0]                   way_hit_i,
  input  logic [WAYS-1:0]                   way_valid_i,
  input  logic [WAYS-1:0]                   way_dirty_i,
  input  logic [WAYS-1:0][TAG_W-1:0]        way_tag_i,
  input  word_t [WAYS-1:0][LINE_WORDS-1:0]  way_line_i,
  output logic                              eng_start_o,
  output logic                              eng_we_o,
  output addr_t                             eng_adr_o,
  output word_t [LINE_WORDS-1:0]            eng_line_o,
  input  logic                              eng_done_i,
  input  word_t [LINE_WORDS-1:0]            eng_line_i
);

  localparam int BYTE_W = $clog2(BE_W);
  localparam int WORD_W = $clog2(LINE_WORDS);
  localparam int OFF_W  = BYTE_W + WORD_W;
  localparam int WAY_W  = (WAYS > 1) ? $clog2(WAYS) : 1;

  typedef enum logic [2:0] {
    S_IDLE, S_LOOKUP, S_EVICT, S_FILL, S_INSTALL, S_FSCAN, S_FWRITE
  } state_e;

  state_e                 state_q, state_d;
  logic [19:0]            lfsr_q;
  logic [WAY_W-1:0]       victim, victim_q, hit_way, dirty_way;
  logic [IDX_W-1:0]       fset_q;      // flush walk set
  logic                   fvld_q;      // flush set read done
  logic                   eng_busy_q;
  logic                   any_dirty;
  logic [WORD_W-1:0]      woff;
  be_t                    be;
  word_t [LINE_WORDS-1:0] src_line;    // line before store merge

  function automatic be_t size2be(mem_size_e size, logic [BYTE_W-1:0] lsb);
    case (size)
      SIZE_BYTE: size2be = be_t'(1) << lsb;
      SIZE_HALF: size2be = be_t'(3) << lsb;
      default:   size2be = '1;
    endcase
  endfunction

  function automatic word_t merge(word_t old_w, word_t new_w, be_t b);
    merge = old_w;
    for (int i = 0; i < BE_W; i++)
      if (b[i]) merge[8*i +: 8] = new_w[8*i +: 8];
  endfunction

  // --------------------
  // decode
  // --------------------
  assign woff     = addr_i[BYTE_W +: WORD_W];
  assign be       = size2be(size_i, addr_i[BYTE_W-1:0]);
  assign victim   = WAY_W'(lfsr_q % WAYS);  // random replacement
  assign src_line = (state_q == S_INSTALL) ? eng_line_i : way_line_i[hit_way];

  // hit way and lowest dirty way
  always_comb
  begin
    hit_way   = '0;
    dirty_way = '0;
    any_dirty = 1'b0;
    for (int w = WAYS - 1; w >= 0; w--)
    begin
      if (way_hit_i[w]) hit_way = WAY_W'(w);
      if (way_valid_i[w] && way_dirty_i[w])
      begin
        dirty_way = WAY_W'(w);
        any_dirty = 1'b1;
      end
    end
  end

  // store data merged into hit or filled line
  always_comb
  begin
    way_line_o = src_line;
    if (we_i)
      way_line_o[woff] = merge(src_line[woff], wdata_i, be);
  end

  // --------------------
  // FSM
  // --------------------
  always_comb
  begin
    state_d       = state_q;
    way_idx_o     = addr_i[OFF_W +: IDX_W];
    way_tag_we_o  = '0;
    way_data_we_o = '0;
    way_tag_o     = addr_i[ADDR_W-1 -: TAG_W];
    way_dirty_o   = we_i;                  // stores leave the line dirty
    eng_start_o   = 1'b0;
    eng_we_o      = 1'b0;
    eng_adr_o     = {addr_i[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
    eng_line_o    = way_line_i[victim];
    case (state_q)
      S_IDLE:
        if (req_i && !ack_o)
          state_d = S_LOOKUP;               // rams read this cycle
        else if (flush_i && !req_i)
          state_d = S_FSCAN;
      S_LOOKUP:
        if (|way_hit_i)
        begin
          way_tag_we_o[hit_way]  = we_i;    // store hit
          way_data_we_o[hit_way] = we_i;
          state_d = S_IDLE;
        end
        else if (way_valid_i[victim] && way_dirty_i[victim])
        begin
          eng_start_o = 1'b1;               // write back victim first
          eng_we_o    = 1'b1;
          eng_adr_o   = {way_tag_i[victim], way_idx_o, {OFF_W{1'b0}}};
          state_d     = S_EVICT;
        end
        else
        begin
          eng_start_o = 1'b1;               // straight to fill
          state_d     = S_FILL;
        end
      S_EVICT:
        if (eng_done_i)
        begin
          eng_start_o = 1'b1;
          state_d     = S_FILL;
        end
      S_FILL:
        if (eng_done_i)
          state_d = S_INSTALL;
      S_INSTALL:
      begin
        way_tag_we_o[victim_q]  = 1'b1;
        way_data_we_o[victim_q] = 1'b1;
        state_d = S_IDLE;
      end
      S_FSCAN:
      begin
        way_idx_o   = fset_q;
        way_tag_o   = way_tag_i[dirty_way];  // keep tag and valid
        way_dirty_o = 1'b0;
        eng_adr_o   = {way_tag_i[dirty_way], fset_q, {OFF_W{1'b0}}};
        eng_line_o  = way_line_i[dirty_way];
        if (fvld_q && any_dirty)
        begin
          way_tag_we_o[dirty_way] = 1'b1;    // clear dirty bit
          eng_start_o = 1'b1;
          eng_we_o    = 1'b1;
          state_d     = S_FWRITE;
        end
        else if (fvld_q && fset_q == IDX_W'(SETS - 1))
          state_d = S_IDLE;                  // walk complete
      end
      S_FWRITE:
      begin
        way_idx_o = fset_q;
        if (eng_done_i)
          state_d = S_FSCAN;                 // rescan for more dirty ways
      end
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q      <= S_IDLE;
      lfsr_q       <= '0;
      victim_q     <= '0;
      fset_q       <= '0;
      fvld_q       <= 1'b0;
      eng_busy_q   <= 1'b0;
      ack_o        <= 1'b0;
      flush_done_o <= 1'b1;
    end
    else
    begin
      state_q <= state_d;
      ack_o   <= (state_q == S_LOOKUP && |way_hit_i) || state_q == S_INSTALL;
      // lfsr frozen during a fill
      if (!(state_q inside {S_EVICT, S_FILL, S_INSTALL}))
        lfsr_q <= {lfsr_q[18:0], lfsr_q[19] ~^ lfsr_q[16]};
      if (state_q == S_LOOKUP)
        victim_q <= victim;
      if (eng_start_o)
        eng_busy_q <= 1'b1;
      else if (eng_done_i)
        eng_busy_q <= 1'b0;
      // flush walk
      fvld_q <= (state_q == S_FSCAN) && !fvld_q;
      if (state_q == S_IDLE && state_d == S_FSCAN)
      begin
        fset_q       <= '0;
        flush_done_o <= 1'b0;
      end
      else if (state_q == S_FSCAN && fvld_q && !any_dirty)
        fset_q <= fset_q + 1'b1;             // set clean, next one
      if (state_q == S_FSCAN && state_d == S_IDLE)
        flush_done_o <= 1'b1;
    end
  end

  // load data for the ack cycle
  always_ff @(posedge clk_i)
    rdata_o <= src_line[woff];

  // one way written per cycle, tag and data the same way
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(way_tag_we_o | way_data_we_o));

  // burst engine never restarted mid burst
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    eng_start_o |-> !eng_busy_q || eng_done_i);

endmodule

/* rtl/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
  parameter int WAYS       = 2,
  parameter int SETS       = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  // cpu side
  input  logic      req_i,
  input  logic      we_i,
  input  addr_t     addr_i,
  input  mem_size_e size_i,
  input  word_t     wdata_i,
  output word_t     rdata_o,
  output logic      ack_o,
  input  logic      flush_i,
  output logic      flush_done_o,
  // memory bus
  output logic      bus_req_o,
  output logic      bus_we_o,
  output addr_t     bus_adr_o,
  input  logic      bus_gnt_i,
  input  word_t     bus_rdata_i,
  input  logic      bus_rvalid_i,
  output word_t     bus_wdata_o,
  input  logic      bus_wready_i
);

  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - IDX_W - $clog2(LINE_WORDS * BE_W);

  // --------------------
  // ctrl to ways
  // --------------------
  logic [IDX_W-1:0]                 way_idx;
  logic [WAYS-1:0]                  way_tag_we, way_data_we;
  logic [TAG_W-1:0]                 way_tag_wr;
  logic                             way_dirty_wr;
  word_t [LINE_WORDS-1:0]           way_line_wr;
  logic [WAYS-1:0]                  way_hit, way_valid, way_dirty;
  logic [WAYS-1:0][TAG_W-1:0]       way_tag;
  word_t [WAYS-1:0][LINE_WORDS-1:0] way_line;

  // ctrl to burst engine
  logic                   eng_start, eng_we, eng_done;
  addr_t                  eng_adr;
  word_t [LINE_WORDS-1:0] eng_line_wr, eng_line_rd;

  dcache_ctrl #(
    .WAYS       (WAYS),
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .we_i          (we_i),
    .addr_i        (addr_i),
    .size_i        (size_i),
    .wdata_i       (wdata_i),
    .rdata_o       (rdata_o),
    .ack_o         (ack_o),
    .flush_i       (flush_i),
    .flush_done_o  (flush_done_o),
    .way_idx_o     (way_idx),
    .way_tag_we_o  (way_tag_we),
    .way_data_we_o (way_data_we),
    .way_tag_o     (way_tag_wr),
    .way_dirty_o   (way_dirty_wr),
    .way_line_o    (way_line_wr),
    .way_hit_i     (way_hit),
    .way_valid_i   (way_valid),
    .way_dirty_i   (way_dirty),
    .way_tag_i     (way_tag),
    .way_line_i    (way_line),
    .eng_start_o   (eng_start),
    .eng_we_o      (eng_we),
    .eng_adr_o     (eng_adr),
    .eng_line_o    (eng_line_wr),
    .eng_done_i    (eng_done),
    .eng_line_i    (eng_line_rd)
  );

  for (genvar g = 0; g < WAYS; g++)
  begin : gen_way
    way_array #(
      .SETS       (SETS),
      .LINE_WORDS (LINE_WORDS)
    ) u_way (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .idx_i     (way_idx),
      .tag_we_i  (way_tag_we[g]),
      .data_we_i (way_data_we[g]),
      .tag_i     (way_tag_wr),
      .dirty_i   (way_dirty_wr),
      .line_i    (way_line_wr),
      .cmp_tag_i (addr_i[ADDR_W-1 -: TAG_W]),  // tag of the request address
      .hit_o     (way_hit[g]),
      .valid_o   (way_valid[g]),
      .dirty_o   (way_dirty[g]),
      .tag_o     (way_tag[g]),
      .line_o    (way_line[g])
    );
  end

  burst_engine #(
    .LINE_WORDS (LINE_WORDS)
  ) u_engine (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .start_i      (eng_start),
    .we_i         (eng_we),
    .adr_i        (eng_adr),
    .line_i       (eng_line_wr),
    .done_o       (eng_done),
    .line_o       (eng_line_rd),
    .bus_req_o    (bus_req_o),
    .bus_we_o     (bus_we_o),
    .bus_adr_o    (bus_adr_o),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rdata_i  (bus_rdata_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_wdata_o  (bus_wdata_o),
    .bus_wready_i (bus_wready_i)
  );

endmodule

/* tb/mem_model.sv */
`timescale 1ns/1ps

module mem_model import dcache_pkg::*; #(
  parameter int          LINE_WORDS = 4,
  parameter int          MEM_WORDS  = 4096,
  parameter logic [31:0] SEED       = 32'hfdd4_36eb
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [1:0] stall_lvl_i,   // 0 never stalls, 3 densest
  input  logic       bus_req_i,
  input  logic       bus_we_i,
  input  addr_t      bus_adr_i,
  output logic       bus_gnt_o,
  output word_t      bus_rdata_o,
  output logic       bus_rvalid_o,
  input  word_t      bus_wdata_i,
  output logic       bus_wready_o
);

  localparam int IDX_W = $clog2(MEM_WORDS);

  word_t       mem_q [MEM_WORDS];  // also read by the testbench
  logic [31:0] lfsr;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // initial content, every address bit folded in
  function automatic word_t fill_word(logic [IDX_W-1:0] idx);
    addr_t a;
    a = addr_t'({idx, 2'b00});
    return {a[18:0], a[31:19]} ^ a ^ 32'hc3a5_5a3c;
  endfunction

  // two lfsr bits per decision
  task automatic draw_stall(output logic stall);
    logic [1:0] r;
    r = '0;
    repeat (2)
    begin
      lfsr = lfsr_next(lfsr);
      r    = {r[0], lfsr[0]};
    end
    stall = (r < stall_lvl_i);
  endtask

  initial
  begin
    logic             stall;
    logic             busy;   // burst in progress
    logic             we_l;
    logic [IDX_W-1:0] ptr;    // current word
    int               left;   // beats still to go
    lfsr         = SEED;
    busy         = 1'b0;
    we_l         = 1'b0;
    ptr          = '0;
    left         = 0;
    bus_gnt_o    = 1'b0;
    bus_rdata_o  = '0;
    bus_rvalid_o = 1'b0;
    bus_wready_o = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++)
      mem_q[IDX_W'(i)] = fill_word(IDX_W'(i));
    forever
    begin
      @(posedge clk_i);
      #1;
      bus_gnt_o    = 1'b0;
      bus_rvalid_o = 1'b0;
      bus_wready_o = 1'b0;
      draw_stall(stall);
      if (!rst_ni)
        busy = 1'b0;
      else if (!busy)
      begin
        if (bus_req_i && !stall)
        begin
          bus_gnt_o = 1'b1;                  // taken at the next edge
          busy      = 1'b1;
          we_l      = bus_we_i;
          ptr       = bus_adr_i[IDX_W+1:2];  // line aligned
          left      = LINE_WORDS;
        end
      end
      else if (!stall)
      begin
        if (we_l)
        begin
          bus_wready_o = 1'b1;
          mem_q[ptr]   = bus_wdata_i;        // consumed at the next edge
        end
        else
        begin
          bus_rvalid_o = 1'b1;
          bus_rdata_o  = mem_q[ptr];
        end
        ptr  = ptr + 1'b1;
        left = left - 1;
        busy = (left != 0);
      end
    end
  end

endmodule

/* tb/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

  localparam int WAYS       = 2;
  localparam int SETS       = 16;
  localparam int LINE_WORDS = 4;
  localparam int MEM_WORDS  = 4096;                  // 16 KB of model memory
  localparam int MEM_IDX_W  = $clog2(MEM_WORDS);
  localparam int CLK_NS     = 8;
  localparam int SET_STRIDE = SETS * LINE_WORDS * BE_W;  // next tag, same set

  // --------------------
  // run length
  // --------------------
  // worst miss is a write burst and a read burst, each beat allowed 16 stall cycles
  localparam int MISS_CYC    = 2 * (LINE_WORDS + 1) * 16 + 8;
  localparam int N_ACCESS    = 128;
  localparam int N_FLUSH     = 2;
  localparam int FLUSH_CYC   = WAYS * SETS * (MISS_CYC + 4);
  localparam int WATCHDOG_NS = (N_ACCESS * (MISS_CYC + 2) + N_FLUSH * FLUSH_CYC + 16) * CLK_NS;

  logic       clk_i;
  logic       rst_ni;
  logic       req_i;
  logic       we_i;
  addr_t      addr_i;
  mem_size_e  size_i;
  word_t      wdata_i;
  word_t      rdata_o;
  logic       ack_o;
  logic       flush_i;
  logic       flush_done_o;
  logic       bus_req_o;
  logic       bus_we_o;
  addr_t      bus_adr_o;
  logic       bus_gnt_i;
  word_t      bus_rdata_i;
  logic       bus_rvalid_i;
  word_t      bus_wdata_o;
  logic       bus_wready_i;
  logic [1:0] stall_lvl;   // memory stall density

  word_t shadow  [MEM_WORDS];  // cpu view of memory
  bit    written [MEM_WORDS];  // words touched by stores
  int    errors;
  int    checks;

  dcache_top #(
    .WAYS       (WAYS),
    .SETS       (SETS),
    .LINE_WORDS (LINE_WORDS)
  ) dut_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .we_i         (we_i),
    .addr_i       (addr_i),
    .size_i       (size_i),
    .wdata_i      (wdata_i),
    .rdata_o      (rdata_o),
    .ack_o        (ack_o),
    .flush_i      (flush_i),
    .flush_done_o (flush_done_o),
    .bus_req_o    (bus_req_o),
    .bus_we_o     (bus_we_o),
    .bus_adr_o    (bus_adr_o),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rdata_i  (bus_rdata_i),
    .bus_rvalid_i (bus_rvalid_i),
    .bus_wdata_o  (bus_wdata_o),
    .bus_wready_i (bus_wready_i)
  );

  mem_model #(
    .LINE_WORDS (LINE_WORDS),
    .MEM_WORDS  (MEM_WORDS)
  ) u_mem (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .stall_lvl_i  (stall_lvl),
    .bus_req_i    (bus_req_o),
    .bus_we_i     (bus_we_o),
    .bus_adr_i    (bus_adr_o),
    .bus_gnt_o    (bus_gnt_i),
    .bus_rdata_o  (bus_rdata_i),
    .bus_rvalid_o (bus_rvalid_i),
    .bus_wdata_i  (bus_wdata_o),
    .bus_wready_o (bus_wready_i)
  );

  always #(CLK_NS / 2) clk_i = ~clk_i;

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Mismatch %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act)
    begin
      errors++;
      $display("Mismatch %s: expected %b actual %b", name, exp, act);
    end
  endtask

  function automatic logic [MEM_IDX_W-1:0] widx(addr_t a);
    return a[MEM_IDX_W+1:2];
  endfunction

  // lanes a store touches, per size and low address bits
  function automatic word_t lane_merge(word_t old_w, word_t new_w, mem_size_e sz,
                                       logic [1:0] lsb);
    word_t res;
    logic  en;
    res = old_w;
    for (int i = 0; i < BE_W; i++)
    begin
      case (sz)
        SIZE_BYTE: en = (2'(i) == lsb);
        SIZE_HALF: en = (2'(i) & 2'b10) == (lsb & 2'b10);  // aligned pair
        default:   en = 1'b1;
      endcase
      if (en)
        res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  // --------------------
  // cpu side
  // --------------------
  // hold the request until ack, then one idle cycle
  task automatic cpu_access(input logic we, input addr_t a, input mem_size_e sz,
                            input word_t wd, output word_t rd, output int cycles);
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = a;
    size_i  = sz;
    wdata_i = wd;
    cycles  = 0;
    do
    begin
      @(posedge clk_i);
      #1;
      cycles++;
    end while (!ack_o && cycles < MISS_CYC);
    if (!ack_o)
    begin
      errors++;
      $display("no ack_o within %0d cycles for address %h", MISS_CYC, a);
    end
    rd    = rdata_o;  // valid in the ack cycle
    req_i = 1'b0;
    we_i  = 1'b0;
    @(posedge clk_i);
    #1;
  endtask

  task automatic store(input addr_t a, input mem_size_e sz, input word_t wd);
    word_t rd;
    int    cycles;
    cpu_access(1'b1, a, sz, wd, rd, cycles);
    shadow[widx(a)]  = lane_merge(shadow[widx(a)], wd, sz, a[1:0]);
    written[widx(a)] = 1'b1;
  endtask

  task automatic load_expect(input string name, input addr_t a, input mem_size_e sz);
    word_t rd;
    int    cycles;
    cpu_access(1'b0, a, sz, '0, rd, cycles);
    check_word($sformatf("%s @%h", name, a), shadow[widx(a)], rd);  // whole word
  endtask

  task automatic store_load(input string name, input addr_t a, input mem_size_e sz,
                            input word_t wd);
    store(a, sz, wd);
    load_expect(name, {a[31:2], 2'b00}, SIZE_WORD);
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic reset_state();
    repeat (2) @(posedge clk_i);
    #1;
    check_bit("in reset ack_o", 1'b0, ack_o);
    check_bit("in reset bus_req_o", 1'b0, bus_req_o);
    check_bit("in reset flush_done_o", 1'b1, flush_done_o);
    rst_ni = 1'b1;
    @(posedge clk_i);
    #1;
    check_bit("after reset ack_o", 1'b0, ack_o);
    check_bit("after reset bus_req_o", 1'b0, bus_req_o);
    check_bit("after reset flush_done_o", 1'b1, flush_done_o);
    for (int i = 0; i < MEM_WORDS; i++)
      shadow[MEM_IDX_W'(i)] = u_mem.mem_q[MEM_IDX_W'(i)];  // initial image
  endtask

  task automatic cold_load(input addr_t a);
    word_t rd;
    int    cycles;
    load_expect("cold load", a, SIZE_WORD);
    cpu_access(1'b0, a, SIZE_WORD, '0, rd, cycles);  // now a hit
    check_word("repeat load", shadow[widx(a)], rd);
    check_bit("hit ack in second cycle", 1'b1, cycles == 2);
    load_expect("cold byte load", a + 32'h23, SIZE_BYTE);  // word comes back unshifted
  endtask

  task automatic merge_stores(input string name, input addr_t base);
    store_load(name, base + 32'd0, SIZE_BYTE, 32'h1122_33a0);
    store_load(name, base + 32'd1, SIZE_BYTE, 32'h4455_b166);
    store_load(name, base + 32'd3, SIZE_BYTE, 32'hc8ff_0102);
    store_load(name, base + 32'd2, SIZE_HALF, 32'hbeef_7788);
    store_load(name, base + 32'd4, SIZE_HALF, 32'h9999_cafe);
    store_load(name, base + 32'd6, SIZE_HALF, 32'hf00d_1234);
    store_load(name, base + 32'd8, SIZE_WORD, 32'h0bad_f00d);
    store_load(name, base + 32'd15, SIZE_BYTE, 32'h5e00_0000);
    load_expect(name, base + 32'd5, SIZE_BYTE);
  endtask

  // six lines in one set of a two way cache
  task automatic set_thrash(input string name, input addr_t base);
    addr_t a;
    for (int k = 0; k < 6; k++)
    begin
      a = base + addr_t'(k * SET_STRIDE);
      store(a, SIZE_WORD, 32'hd00d_0000 + word_t'(k * 273));
      store(a + 32'd5, SIZE_BYTE, 32'h0000_4b00 ^ word_t'(k << 8));
    end
    for (int k = 0; k < 6; k++)
    begin
      a = base + addr_t'(k * SET_STRIDE);
      load_expect(name, a, SIZE_WORD);
      load_expect(name, a + 32'd4, SIZE_WORD);
    end
    for (int k = 5; k >= 0; k--)  // reverse order, other victims
    begin
      a = base + addr_t'(k * SET_STRIDE);
      load_expect(name, a, SIZE_WORD);
      load_expect(name, a + 32'd4, SIZE_WORD);
    end
  endtask

  task automatic flush_compare(input string name);
    int cycles;
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    check_bit({name, " flush_done_o low"}, 1'b0, flush_done_o);
    cycles = 0;
    while (!flush_done_o && cycles < FLUSH_CYC)
    begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    if (!flush_done_o)
    begin
      errors++;
      $display("%s: flush_done_o did not rise within %0d cycles", name, FLUSH_CYC);
    end
    for (int i = 0; i < MEM_WORDS; i++)
      if (written[MEM_IDX_W'(i)])
        check_word($sformatf("%s mem @%h", name, i * 4), shadow[MEM_IDX_W'(i)],
                   u_mem.mem_q[MEM_IDX_W'(i)]);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial
  begin
    clk_i     = 1'b0;
    rst_ni    = 1'b0;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    size_i    = SIZE_WORD;
    wdata_i   = '0;
    flush_i   = 1'b0;
    stall_lvl = 2'd1;  // light stalls first
    errors    = 0;
    checks    = 0;
    reset_state();
    cold_load(32'h0000_0040);
    merge_stores("merge", 32'h0000_0200);
    set_thrash("thrash", 32'h0000_0330);
    flush_compare("flush");
    stall_lvl = 2'd3;
    merge_stores("merge stalled", 32'h0000_1280);
    set_thrash("thrash stalled", 32'h0000_2530);
    flush_compare("flush stalled");
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("run did not finish within %0d ns", WATCHDOG_NS);
    $display("checks %0d, errors %0d", checks, errors);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* src.f */
rtl/dcache_pkg.sv
rtl/cache_ram.sv
rtl/way_array.sv
rtl/burst_engine.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
tb/mem_model.sv
tb/tb_dcache.sv

/* run.sh */
#!/bin/sh
# build and run the dcache testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_dcache -f src.f -o sim_dcache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_dcache)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# pass only if the testbench printed its pass line
if echo "$out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
